/* build.f */
+incdir+common
common/vgaVideoPkg.sv
common/vgaBusPkg.sv
vga/vgaTiming.sv
vga/vgaPattern.sv
rtl/vgaRegs.sv
rtl/vgaTop.sv
tests/vgaTb.sv

/* Makefile */
# Verilator build and run for the VGA controller testbench
VERILATOR ?= verilator
TOP ?= vgaTb
FILELIST ?= build.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS ?= Result: PASSED

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJDIR)

/* tests/vgaTb.sv */
/*
 * Testbench for vgaTop. Checks every pixel and both syncs of whole frames at the
 * pixel rate, so one run spans about ten frames of simulated time
 */
`timescale 1ns/1ps
`default_nettype none

module vgaTb
	import vgaVideoPkg::*;
	import vgaBusPkg::*;
();

	localparam int HTotal = 800;
	localparam int VTotal = 525;
	localparam int HVisible = 640;
	localparam int VVisible = 480;
	localparam int HSyncFirst = 656;
	localparam int HSyncLast = 751;
	localparam int VSyncFirst = 490;
	localparam int VSyncLast = 491;
	localparam int AckLimit = 16;
	localparam int PrintLimit = 50;
	localparam int NumRows = 7;

	typedef struct packed {
		logic enable;
		modeT mode;
		rgbT color;
		logic [3:0] frames;
	} rowT;

	// enable, mode, solid color, frames to watch
	localparam rowT StimRows [NumRows] = '{
		'{1'b0, BARS, 3'd5, 4'd1},
		'{1'b1, SOLID, 3'd3, 4'd1},
		'{1'b1, SOLID, 3'd4, 4'd1},
		'{1'b1, TRIAD, 3'd0, 4'd1},
		'{1'b1, BARS, 3'd0, 4'd1},
		'{1'b1, CHECKER, 3'd2, 4'd1},
		'{1'b1, CHECKER, 3'd5, 4'd2}
	};

	logic Clock;
	logic Reset;
	wbReqT wbReq;
	wbRspT wbRsp;
	logic red;
	logic green;
	logic blue;
	logic hSync;
	logic vSync;

	videoCfgT model;
	logic aligned;
	logic lastVSync;
	int hPos;
	int vPos;
	int vFalls;
	int colorErrors;
	int syncErrors;
	int regErrors;
	int otherErrors;
	int printed;

	vgaTop dut0 (
		.Clock(Clock),
		.Reset(Reset),
		.wbReq_i(wbReq),
		.wbRsp_o(wbRsp),
		.red_o(red),
		.green_o(green),
		.blue_o(blue),
		.hSync_o(hSync),
		.vSync_o(vSync)
	);

	initial begin
		Clock = 1'b0;
		forever #20 Clock = ~Clock;
	end

	task automatic showMismatch(string name, logic [31:0] expected, logic [31:0] actual);
		if (printed < PrintLimit)
			$display("error at %0t ns: %s expected %0h actual %0h (h %0d, v %0d)",
				$time, name, expected, actual, hPos, vPos);
		else if (printed == PrintLimit)
			$display("too many mismatches, later error lines are not shown");
		printed++;
	endtask

	task automatic checkColor(string name, rgbT expected, rgbT actual);
		if (actual !== expected) begin
			colorErrors++;
			showMismatch(name, 32'(expected), 32'(actual));
		end
	endtask

	task automatic checkBit(string name, logic expected, logic actual);
		if (actual !== expected) begin
			syncErrors++;
			showMismatch(name, 32'(expected), 32'(actual));
		end
	endtask

	task automatic checkReg(string name, wbDataT expected, wbDataT actual);
		if (actual !== expected) begin
			regErrors++;
			showMismatch(name, expected, actual);
		end
	endtask

	// Color that the port should show at a scan position
	function automatic rgbT expectedColor(int h, int v, videoCfgT cfg);
		rgbT c;
		if (!cfg.enable || h >= HVisible || v >= VVisible) begin
			c = '0;
		end else begin
			case (cfg.mode)
				SOLID: c = cfg.color;
				TRIAD: c = rgbT'(1 << (h % 3));
				BARS: c = rgbT'((h >> 6) & 7);
				default: c = (((h >> 5) & 1) != ((v >> 5) & 1)) ? 3'b111 : cfg.color;
			endcase
		end
		return c;
	endfunction

	// One pixel clock: move the tracker, then check the port
	task automatic stepCycle();
		@(negedge Clock);
		if (aligned) begin
			hPos = hPos + 1;
			if (hPos == HTotal) begin
				hPos = 0;
				vPos = (vPos == VTotal - 1) ? 0 : vPos + 1;
			end
		end else if (lastVSync && !vSync) begin
			// First low vSync marks pixel 0 of line 490
			aligned = 1'b1;
			hPos = 0;
			vPos = VSyncFirst;
		end
		if (aligned) begin
			checkBit("hSync_o", !(hPos >= HSyncFirst && hPos <= HSyncLast), hSync);
			checkBit("vSync_o", !(vPos >= VSyncFirst && vPos <= VSyncLast), vSync);
			checkColor("rgb", expectedColor(hPos, vPos, model), {blue, green, red});
		end
		if (lastVSync && !vSync)
			vFalls++;
		lastVSync = vSync;
	endtask

	task automatic runUntil(int h, int v);
		do begin
			stepCycle();
		end while (!(aligned && hPos == h && vPos == v));
	endtask

	task automatic busAccess(logic write, regIdxT addr, wbDataT wdata, output wbDataT rdata);
		int waited;
		waited = 0;
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we = write;
		wbReq.adr = addr;
		wbReq.dat = wdata;
		do begin
			stepCycle();
			waited++;
		end while (!wbRsp.ack && waited < AckLimit);
		if (!wbRsp.ack) begin
			otherErrors++;
			$display("no ack on register %s within %0d cycles", addr.name(), AckLimit);
		end
		rdata = wbRsp.dat;
		// Strobe stays high over the edge that ends the handshake
		stepCycle();
		wbReq = '0;
		if (wbRsp.ack !== 1'b0) begin
			otherErrors++;
			$display("ack on register %s stayed high past one cycle", addr.name());
		end
	endtask

	task automatic writeReg(regIdxT addr, wbDataT data);
		wbDataT unused;
		busAccess(1'b1, addr, data, unused);
	endtask

	task automatic readReg(regIdxT addr, output wbDataT data);
		busAccess(1'b0, addr, '0, data);
	endtask

	initial begin : watchdog
		longint limitNs;
		int frames;
		frames = 0;
		for (int i = 0; i < NumRows; i++)
			frames += int'(StimRows[i].frames);
		limitNs = longint'(frames + 2) * HTotal * VTotal * 40;
		#(limitNs);
		$display("timeout, the run did not finish within %0d ns", limitNs);
		$display("Result: FAILED");
		$finish;
	end

	initial begin : mainFlow
		wbDataT rd;
		wbDataT frameBefore;
		wbDataT frameAfter;
		wbDataT ctrlValue;
		rowT row;
		Reset = 1'b0;
		wbReq = '0;
		model = '0;
		aligned = 1'b0;
		lastVSync = 1'b1;
		hPos = 0;
		vPos = 0;
		vFalls = 0;
		colorErrors = 0;
		syncErrors = 0;
		regErrors = 0;
		otherErrors = 0;
		printed = 0;
		repeat (2) @(posedge Clock);
		@(negedge Clock);
		// Still inside reset here
		checkBit("hSync_o", 1'b1, hSync);
		checkBit("vSync_o", 1'b1, vSync);
		checkColor("rgb", '0, {blue, green, red});
		checkBit("ack", 1'b0, wbRsp.ack);
		Reset = 1'b1;
		readReg(CTRL, rd);
		checkReg("CTRL", '0, rd);
		while (!aligned)
			stepCycle();
		// Disabled frame runs out to the start of vertical blanking
		runUntil(0, VVisible);
		for (int i = 0; i < NumRows; i++) begin
			row = StimRows[i];
			ctrlValue = wbDataT'({row.mode, row.enable});
			readReg(FRAME, frameBefore);
			vFalls = 0;
			writeReg(FRAME, wbDataT'(32'h00a5_5a00 + i));
			readReg(FRAME, rd);
			checkReg("FRAME", frameBefore, rd);
			writeReg(CTRL, ctrlValue);
			writeReg(COLOR, wbDataT'(row.color));
			model = '{row.enable, row.mode, row.color};
			readReg(CTRL, rd);
			checkReg("CTRL", ctrlValue, rd);
			readReg(COLOR, rd);
			checkReg("COLOR", wbDataT'(row.color), rd);
			readReg(LINE, rd);
			if (rd > wbDataT'(VTotal - 1)) begin
				otherErrors++;
				$display("LINE read %0d, which is past the last line", rd);
			end
			repeat (int'(row.frames))
				runUntil(0, VVisible);
			readReg(FRAME, frameAfter);
			checkReg("FRAME delta", wbDataT'(vFalls), (frameAfter - frameBefore) & 32'hffff);
		end
		$display("errors: color %0d, sync %0d, register %0d, other %0d",
			colorErrors, syncErrors, regErrors, otherErrors);
		if (colorErrors + syncErrors + regErrors + otherErrors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/vgaTop.sv */
/*
 * VGA controller top. Clock must be the 25 MHz pixel clock, the register bus
 * shares it. Video lags the internal counters by two clocks
 */
`timescale 1ns/1ps
`default_nettype none

module vgaTop
	import vgaVideoPkg::*;
	import vgaBusPkg::*;
(
	input  wire   Clock,
	input  wire   Reset,
	input  wbReqT wbReq_i,
	output wbRspT wbRsp_o,
	output logic  red_o,
	output logic  green_o,
	output logic  blue_o,
	output logic  hSync_o,
	output logic  vSync_o
);

	logic frameWrap;
	beamT beam;
	videoCfgT cfg;

	vgaRegs regs0 (
		.Clock(Clock),
		.Reset(Reset),
		.wbReq_i(wbReq_i),
		.wbRsp_o(wbRsp_o),
		.frameWrap_i(frameWrap),
		.line_i(beam.vCount),
		.cfg_o(cfg)
	);

	vgaTiming timing0 (
		.Clock(Clock),
		.Reset(Reset),
		.frameWrap_o(frameWrap),
		.beam_o(beam)
	);

	vgaPattern pattern0 (
		.Clock(Clock),
		.Reset(Reset),
		.beam_i(beam),
		.cfg_i(cfg),
		.red_o(red_o),
		.green_o(green_o),
		.blue_o(blue_o),
		.hSync_o(hSync_o),
		.vSync_o(vSync_o)
	);

endmodule

`default_nettype wire

/* rtl/vgaRegs.sv */
/*
 * Wishbone classic slave, one-cycle ack, no wait states and no error response.
 * FRAME and LINE are read-only, writes to them are dropped
 */
`timescale 1ns/1ps
`default_nettype none

module vgaRegs
	import vgaVideoPkg::*;
	import vgaBusPkg::*;
(
	input  wire       Clock,
	input  wire       Reset,
	input  wbReqT     wbReq_i,
	output wbRspT     wbRsp_o,
	input  wire       frameWrap_i,
	input  countT     line_i,
	output videoCfgT  cfg_o
);

	logic ackR;
	logic access;
	regIdxT idx;
	ctrlFieldT ctrlWr;
	ctrlFieldT ctrlRd;
	videoCfgT cfgR;
	frameCountT frameCount;
	wbDataT readMux;
	wbDataT rdData;

	// New access only while ack is low, so each strobe is acked once
	assign access = wbReq_i.cyc && wbReq_i.stb && !ackR;
	assign idx = regIdxT'(wbReq_i.adr);
	assign ctrlWr = ctrlFieldT'(wbReq_i.dat[$bits(ctrlFieldT)-1:0]);
	assign ctrlRd = '{mode: cfgR.mode, enable: cfgR.enable};

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			ackR <= 1'b0;
		end else begin
			ackR <= access;
		end
	end

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			cfgR <= '{enable: 1'b0, mode: SOLID, color: '0};
		end else if (access && wbReq_i.we) begin
			case (idx)
				CTRL: begin
					cfgR.enable <= ctrlWr.enable;
					cfgR.mode <= modeT'(ctrlWr.mode);
				end
				COLOR: cfgR.color <= rgbT'(wbReq_i.dat[2:0]);
				default: ;
			endcase
		end
	end

	// Counts wraps of the scan, not sync edges
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			frameCount <= '0;
		end else if (frameWrap_i) begin
			frameCount <= frameCount + 1'b1;
		end
	end

	always_comb begin
		case (idx)
			CTRL: readMux = wbDataT'(ctrlRd);
			COLOR: readMux = wbDataT'(cfgR.color);
			FRAME: readMux = wbDataT'(frameCount);
			LINE: readMux = wbDataT'(line_i);
			default: readMux = '0;
		endcase
	end

	// Captured on the ack edge, held until the next access
	always_ff @(posedge Clock) begin
		if (access)
			rdData <= readMux;
	end

	assign wbRsp_o = '{ack: ackR, dat: rdData};
	assign cfg_o = cfgR;

	ackNeedsStb: assert property (@(posedge Clock) disable iff (!Reset)
		wbRsp_o.ack |-> wbReq_i.stb)
		else $error("ack raised without stb");

endmodule

`default_nettype wire

/* vga/vgaPattern.sv */
/*
 * Pattern select and output register. Adds one clock, colors and syncs leave together.
 * Config changes apply from the next pixel, there is no frame-boundary latch
 */
`timescale 1ns/1ps
`default_nettype none

`include "vga_config.svh"

module vgaPattern
	import vgaVideoPkg::*;
(
	input  wire      Clock,
	input  wire      Reset,
	input  beamT     beam_i,
	input  videoCfgT cfg_i,
	output logic     red_o,
	output logic     green_o,
	output logic     blue_o,
	output logic     hSync_o,
	output logic     vSync_o
);

	localparam countT LineLast = countT'(`VGA_H_BACK);
	localparam rgbT Red = 3'b001;
	localparam rgbT White = 3'b111;

	rgbT ring;
	rgbT pick;

	// One-hot color for the beam position, reloaded to red ahead of pixel 0
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			ring <= Red;
		end else if (beam_i.hCount == LineLast) begin
			ring <= Red;
		end else begin
			ring <= {ring[1:0], ring[2]};
		end
	end

	always_comb begin
		case (cfg_i.mode)
			SOLID: pick = cfg_i.color;
			TRIAD: pick = ring;
			BARS: pick = rgbT'(beam_i.hCount[8:6]);
			CHECKER: begin
				if (beam_i.hCount[5] != beam_i.vCount[5])
					pick = White;
				else
					pick = cfg_i.color;
			end
			default: pick = cfg_i.color;
		endcase
	end

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			{blue_o, green_o, red_o} <= '0;
			hSync_o <= 1'b1;
			vSync_o <= 1'b1;
		end else begin
			// Blank outside the window or when disabled
			if (cfg_i.enable && beam_i.active)
				{blue_o, green_o, red_o} <= pick;
			else
				{blue_o, green_o, red_o} <= '0;
			hSync_o <= beam_i.hSync;
			vSync_o <= beam_i.vSync;
		end
	end

	blankDuringSync: assert property (@(posedge Clock) disable iff (!Reset)
		(!hSync_o || !vSync_o) |-> ({blue_o, green_o, red_o} == 3'b000))
		else $error("color driven while a sync is low");

endmodule

`default_nettype wire

/* vga/vgaTiming.sv */
/*
 * Free running scan counters, no enable and no stall. The beam output lags the
 * counters by one clock and leaves reset at position (799, 524)
 */
`timescale 1ns/1ps
`default_nettype none

`include "vga_config.svh"

module vgaTiming
	import vgaVideoPkg::*;
(
	input  wire  Clock,
	input  wire  Reset,
	output logic frameWrap_o,
	output beamT beam_o
);

	localparam countT HActiveEnd = countT'(`VGA_H_ACTIVE);
	localparam countT HFrontEnd = countT'(`VGA_H_FRONT);
	localparam countT HSyncEnd = countT'(`VGA_H_SYNC);
	localparam countT HBackEnd = countT'(`VGA_H_BACK);
	localparam countT VActiveEnd = countT'(`VGA_V_ACTIVE);
	localparam countT VFrontEnd = countT'(`VGA_V_FRONT);
	localparam countT VSyncEnd = countT'(`VGA_V_SYNC);
	localparam countT VBackEnd = countT'(`VGA_V_BACK);

	countT hCount;
	countT vCount;
	phaseT hPhase;
	phaseT vPhase;
	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (hCount == HBackEnd);
	assign frameEnd = lineEnd && (vCount == VBackEnd);

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			hCount <= '0;
			vCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0;
			vCount <= (vCount == VBackEnd) ? '0 : vCount + 1'b1;
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	// Phase tracks the current hCount, switching after each phase end
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			hPhase <= ACTIVE;
		end else begin
			case (hPhase)
				ACTIVE: if (hCount == HActiveEnd) hPhase <= FRONT;
				FRONT: if (hCount == HFrontEnd) hPhase <= SYNC;
				SYNC: if (hCount == HSyncEnd) hPhase <= BACK;
				BACK: if (hCount == HBackEnd) hPhase <= ACTIVE;
				default: hPhase <= ACTIVE;
			endcase
		end
	end

	// Vertical phase only moves on the last pixel of a line
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			vPhase <= ACTIVE;
		end else if (lineEnd) begin
			case (vPhase)
				ACTIVE: if (vCount == VActiveEnd) vPhase <= FRONT;
				FRONT: if (vCount == VFrontEnd) vPhase <= SYNC;
				SYNC: if (vCount == VSyncEnd) vPhase <= BACK;
				BACK: if (vCount == VBackEnd) vPhase <= ACTIVE;
				default: vPhase <= ACTIVE;
			endcase
		end
	end

	// Beam register, one clock behind the counters
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			beam_o <= '{hCount: HBackEnd, vCount: VBackEnd, active: 1'b0,
				hSync: 1'b1, vSync: 1'b1};
			frameWrap_o <= 1'b0;
		end else begin
			beam_o.hCount <= hCount;
			beam_o.vCount <= vCount;
			beam_o.active <= (hPhase == ACTIVE) && (vPhase == ACTIVE);
			beam_o.hSync <= (hPhase != SYNC);
			beam_o.vSync <= (vPhase != SYNC);
			// High for one clock as the counters restart at (0, 0)
			frameWrap_o <= frameEnd;
		end
	end

	countInRange: assert property (@(posedge Clock) disable iff (!Reset)
		(hCount <= HBackEnd) && (vCount <= VBackEnd))
		else $error("scan counter beyond its maximum");

	// hSync low only inside its counter window, so never over active pixels
	noSyncWhileActive: assert property (@(posedge Clock) disable iff (!Reset)
		!beam_o.hSync |-> (beam_o.hCount > HFrontEnd) && (beam_o.hCount <= HSyncEnd))
		else $error("hSync low outside its counter window");

endmodule

`default_nettype wire

/* common/vgaBusPkg.sv */
/*
 * Wishbone classic register bus types, four word addresses, no byte selects
 */
`default_nettype none

`include "vga_config.svh"

package vgaBusPkg;

	typedef logic [`VGA_WB_DW-1:0] wbDataT;
	typedef logic [`VGA_WB_AW-1:0] wbAddrT;

	// Frame counter wraps at 16 bits
	typedef logic [15:0] frameCountT;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wbAddrT adr;
		wbDataT dat;
	} wbReqT;

	typedef struct packed {
		logic ack;
		wbDataT dat;
	} wbRspT;

	typedef enum logic [`VGA_WB_AW-1:0] {
		CTRL = 2'd0,
		COLOR = 2'd1,
		FRAME = 2'd2,
		LINE = 2'd3
	} regIdxT;

	// Low bits of CTRL, enable in bit 0
	typedef struct packed {
		logic [1:0] mode;
		logic enable;
	} ctrlFieldT;

endpackage

`default_nettype wire

/* common/vgaVideoPkg.sv */
/*
 * Picture side types. Color is 3 bits, red in bit 0 and blue in bit 2
 */
`default_nettype none

`include "vga_config.svh"

package vgaVideoPkg;

	typedef logic [`VGA_COUNT_W-1:0] countT;

	// Same four phases for both counters
	typedef enum logic [1:0] {
		ACTIVE,
		FRONT,
		SYNC,
		BACK
	} phaseT;

	typedef logic [2:0] rgbT;

	typedef enum logic [1:0] {
		SOLID,
		TRIAD,
		BARS,
		CHECKER
	} modeT;

	// One scan position, syncs active low
	typedef struct packed {
		countT hCount;
		countT vCount;
		logic active;
		logic hSync;
		logic vSync;
	} beamT;

	typedef struct packed {
		logic enable;
		modeT mode;
		rgbT color;
	} videoCfgT;

endpackage

`default_nettype wire

/* common/vga_config.svh */
/*
 * Fixed 640x480 at 60 Hz timing, assumes a 25 MHz pixel clock supplied from outside.
 * Each value is the last count of its phase, so porch and sync widths follow from the differences
 */
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

// Horizontal phase ends, in pixels
`define VGA_H_ACTIVE 639
`define VGA_H_FRONT 655
`define VGA_H_SYNC 751
`define VGA_H_BACK 799

// Vertical phase ends, in lines
`define VGA_V_ACTIVE 479
`define VGA_V_FRONT 489
`define VGA_V_SYNC 491
`define VGA_V_BACK 524

// Wide enough for 799 and 524
`define VGA_COUNT_W 10

// Register bus
`define VGA_WB_DW 32
`define VGA_WB_AW 2

`endif
